//--- src/ex_pkg.sv
//////////////////////////////////////////////////////////////////////
// Shared widths, opcodes and bundles for the RV32 execute stage
// Imported by every RTL block and by the testbench
//////////////////////////////////////////////////////////////////////

package ex_pkg;

  // Data path and register address widths
  localparam int unsigned XLEN       = 32;
  localparam int unsigned REG_ADDR_W = 5;

  //////////////////////////////////////////////////////////////////////
  // Opcodes
  //////////////////////////////////////////////////////////////////////

  // ALU operations, last six are branch compares
  typedef enum logic [3:0] {
    ADD  = 4'h0,
    SUB  = 4'h1,
    AND  = 4'h2,
    OR   = 4'h3,
    XOR  = 4'h4,
    SLL  = 4'h5,
    SRL  = 4'h6,
    SRA  = 4'h7,
    SLT  = 4'h8,
    SLTU = 4'h9,
    EQ   = 4'ha,
    NE   = 4'hb,
    LT   = 4'hc,
    GE   = 4'hd,
    LTU  = 4'he,
    GEU  = 4'hf
  } alu_op_e;

  // Multiplier operations
  typedef enum logic [1:0] {
    MUL    = 2'b00,
    MULH   = 2'b01,
    MULHSU = 2'b10,
    MULHU  = 2'b11
  } mult_op_e;

  // High-word multiply sequence, one partial product per state
  typedef enum logic [1:0] {
    MULT_IDLE = 2'b00,
    MULT_ALBH = 2'b01,
    MULT_AHBL = 2'b10,
    MULT_AHBH = 2'b11
  } mult_state_e;

  //////////////////////////////////////////////////////////////////////
  // Bundles
  //////////////////////////////////////////////////////////////////////

  // One issued instruction from decode
  typedef struct packed {
    logic                  alu_en;
    alu_op_e               alu_op;
    logic                  mult_en;
    mult_op_e              mult_op;
    logic [XLEN-1:0]       op_a;
    logic [XLEN-1:0]       op_b;
    logic [XLEN-1:0]       op_c;
    // Forwarding port destination
    logic                  fw_we;
    logic [REG_ADDR_W-1:0] fw_waddr;
    // Load destination
    logic                  lsu_en;
    logic                  lsu_we;
    logic [REG_ADDR_W-1:0] lsu_waddr;
    logic                  csr_access;
    logic [XLEN-1:0]       csr_rdata;
    logic                  branch;
  } ex_issue_t;

  // One register file write
  typedef struct packed {
    logic                  we;
    logic [REG_ADDR_W-1:0] waddr;
    logic [XLEN-1:0]       wdata;
  } rf_wr_t;

endpackage

//--- src/ex_alu.sv
//////////////////////////////////////////////////////////////////////
// Single-cycle integer ALU with branch compare output
// Purely combinational, result valid in the cycle the operands appear
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module ex_alu (
  input  ex_pkg::alu_op_e         operator_i,
  input  logic [ex_pkg::XLEN-1:0] operand_a_i,
  input  logic [ex_pkg::XLEN-1:0] operand_b_i,
  output logic [ex_pkg::XLEN-1:0] result_o,
  output logic                    comparison_result_o
);
  import ex_pkg::*;

  logic            is_signed;
  logic            is_sub;
  logic            is_arith;
  logic [XLEN:0]   adder_a;
  logic [XLEN:0]   adder_b;
  logic [XLEN:0]   adder_sum;
  logic            is_equal;
  logic            is_less;
  logic [4:0]      shamt;
  logic [XLEN-1:0] shift_left;
  logic [XLEN:0]   shift_right;

  //////////////////////////////////////////////////////////////////////
  // Shared adder
  //////////////////////////////////////////////////////////////////////

  // Signed compares extend with the sign bit, unsigned with zero
  assign is_signed = operator_i inside {SLT, LT, GE};
  // Everything except ADD goes through as a - b
  assign is_sub    = (operator_i != ADD);

  assign adder_a   = {is_signed & operand_a_i[XLEN-1], operand_a_i};
  assign adder_b   = {is_signed & operand_b_i[XLEN-1], operand_b_i};
  assign adder_sum = adder_a + (is_sub ? ~adder_b : adder_b) + {{XLEN{1'b0}}, is_sub};

  // Extra bit is the sign of the exact difference
  assign is_less   = adder_sum[XLEN];
  assign is_equal  = (adder_sum[XLEN-1:0] == '0);

  //////////////////////////////////////////////////////////////////////
  // Shifter
  //////////////////////////////////////////////////////////////////////

  // Only the low five bits of b count
  assign shamt       = operand_b_i[4:0];
  assign is_arith    = (operator_i == SRA);
  assign shift_left  = operand_a_i << shamt;
  // One extra bit carries the fill value for SRA
  assign shift_right = $signed({is_arith & operand_a_i[XLEN-1], operand_a_i}) >>> shamt;

  // Branch compare
  always_comb begin
    case (operator_i)
      EQ:       comparison_result_o = is_equal;
      NE:       comparison_result_o = ~is_equal;
      LT, LTU:  comparison_result_o = is_less;
      GE, GEU:  comparison_result_o = ~is_less;
      SLT:      comparison_result_o = is_less;
      SLTU:     comparison_result_o = is_less;
      default:  comparison_result_o = 1'b0;
    endcase
  end

  // Result select
  always_comb begin
    case (operator_i)
      ADD, SUB:  result_o = adder_sum[XLEN-1:0];
      AND:       result_o = operand_a_i & operand_b_i;
      OR:        result_o = operand_a_i | operand_b_i;
      XOR:       result_o = operand_a_i ^ operand_b_i;
      SLL:       result_o = shift_left;
      SRL, SRA:  result_o = shift_right[XLEN-1:0];
      // Set and compare ops return the flag in bit 0
      default:   result_o = {{(XLEN-1){1'b0}}, comparison_result_o};
    endcase
  end

endmodule

//--- src/ex_mult.sv
//////////////////////////////////////////////////////////////////////
// Integer multiplier for MUL, MULH, MULHSU and MULHU
// MUL finishes in one cycle, high-word ops take four cycles and
// hold ready_o low for the first three
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module ex_mult (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    enable_i,
  input  ex_pkg::mult_op_e        operator_i,
  input  logic [ex_pkg::XLEN-1:0] op_a_i,
  input  logic [ex_pkg::XLEN-1:0] op_b_i,
  input  logic                    ex_ready_i,
  output logic [ex_pkg::XLEN-1:0] result_o,
  output logic                    ready_o
);
  import ex_pkg::*;

  localparam int unsigned HALF_W = XLEN / 2;

  mult_state_e                 state_q;
  mult_state_e                 state_d;
  logic                        a_signed;
  logic                        b_signed;
  logic [HALF_W:0]             a_lo;
  logic [HALF_W:0]             a_hi;
  logic [HALF_W:0]             b_lo;
  logic [HALF_W:0]             b_hi;
  logic [HALF_W:0]             pp_a;
  logic [HALF_W:0]             pp_b;
  logic signed [2*HALF_W+1:0]  pp;
  logic [2*XLEN-1:0]           pp_ext;
  logic [2*XLEN-1:0]           pp_shifted;
  logic [2*XLEN-1:0]           acc_q;
  logic [2*XLEN-1:0]           acc_d;
  logic [XLEN-1:0]             prod_ll;
  logic [XLEN-1:0]             prod_lh;
  logic [XLEN-1:0]             prod_hl;
  logic [XLEN-1:0]             mul_low;

  //////////////////////////////////////////////////////////////////////
  // Low word, single cycle
  //////////////////////////////////////////////////////////////////////

  assign prod_ll = op_a_i[HALF_W-1:0] * op_b_i[HALF_W-1:0];
  assign prod_lh = op_a_i[HALF_W-1:0] * op_b_i[XLEN-1:HALF_W];
  assign prod_hl = op_a_i[XLEN-1:HALF_W] * op_b_i[HALF_W-1:0];
  // Cross terms only reach the upper half, high x high drops out
  assign mul_low = prod_ll + {prod_lh[HALF_W-1:0] + prod_hl[HALF_W-1:0], {HALF_W{1'b0}}};

  //////////////////////////////////////////////////////////////////////
  // High word, one 17x17 partial product per cycle
  //////////////////////////////////////////////////////////////////////

  assign a_signed = (operator_i == MULH) || (operator_i == MULHSU);
  assign b_signed = (operator_i == MULH);

  // Low halves always unsigned, upper halves carry the operand sign
  assign a_lo = {1'b0, op_a_i[HALF_W-1:0]};
  assign a_hi = {a_signed & op_a_i[XLEN-1], op_a_i[XLEN-1:HALF_W]};
  assign b_lo = {1'b0, op_b_i[HALF_W-1:0]};
  assign b_hi = {b_signed & op_b_i[XLEN-1], op_b_i[XLEN-1:HALF_W]};

  always_comb begin
    case (state_q)
      MULT_IDLE: begin
        pp_a       = a_lo;
        pp_b       = b_lo;
        pp_shifted = pp_ext;
      end
      MULT_ALBH: begin
        pp_a       = a_lo;
        pp_b       = b_hi;
        pp_shifted = pp_ext << HALF_W;
      end
      MULT_AHBL: begin
        pp_a       = a_hi;
        pp_b       = b_lo;
        pp_shifted = pp_ext << HALF_W;
      end
      default: begin
        pp_a       = a_hi;
        pp_b       = b_hi;
        pp_shifted = pp_ext << XLEN;
      end
    endcase
  end

  assign pp     = $signed(pp_a) * $signed(pp_b);
  assign pp_ext = {{(2*XLEN-2*HALF_W-2){pp[2*HALF_W+1]}}, pp};
  // First step starts a fresh sum
  assign acc_d  = ((state_q == MULT_IDLE) ? '0 : acc_q) + pp_shifted;

  // Accumulator frozen in the last state while waiting for ex_ready_i
  always_ff @(posedge clk) begin
    if (state_q != MULT_AHBH) begin
      acc_q <= acc_d;
    end
  end

  // Sequence control
  always_comb begin
    state_d = state_q;
    ready_o = 1'b1;
    case (state_q)
      MULT_IDLE: begin
        if (enable_i && (operator_i != MUL)) begin
          ready_o = 1'b0;
          state_d = MULT_ALBH;
        end
      end
      MULT_ALBH: begin
        ready_o = 1'b0;
        state_d = MULT_AHBL;
      end
      MULT_AHBL: begin
        ready_o = 1'b0;
        state_d = MULT_AHBH;
      end
      default: begin
        // Result on the port, leave once the stage accepts it
        if (ex_ready_i) begin
          state_d = MULT_IDLE;
        end
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MULT_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign result_o = (operator_i == MUL) ? mul_low : acc_d[2*XLEN-1:XLEN];

endmodule

//--- src/ex_stage.sv
//////////////////////////////////////////////////////////////////////
// Execute stage: ALU, multiplier, forwarding write port and the
// EX/WB register for load write-back
// Decode holds issue_i stable while ex_ready_o is low
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module ex_stage (
  input  logic                    clk,
  input  logic                    rst_n,
  input  ex_pkg::ex_issue_t       issue_i,
  input  logic                    wb_ready_i,
  input  logic                    lsu_ready_ex_i,
  input  logic [ex_pkg::XLEN-1:0] lsu_rdata_i,
  input  logic                    lsu_err_i,
  output ex_pkg::rf_wr_t          fw_wr_o,
  output ex_pkg::rf_wr_t          wb_wr_o,
  output logic                    branch_decision_o,
  output logic [ex_pkg::XLEN-1:0] jump_target_o,
  output logic                    ex_ready_o,
  output logic                    ex_valid_o
);
  import ex_pkg::*;

  logic [XLEN-1:0]       alu_result;
  logic                  alu_cmp_result;
  logic [XLEN-1:0]       mult_result;
  logic                  mult_ready;
  logic                  units_ready;
  logic                  has_work;
  logic                  load_wr;
  logic                  lsu_we_q;
  logic [REG_ADDR_W-1:0] lsu_waddr_q;

  //////////////////////////////////////////////////////////////////////
  // Functional units
  //////////////////////////////////////////////////////////////////////

  ex_alu u_alu (
    .operator_i          (issue_i.alu_op),
    .operand_a_i         (issue_i.op_a),
    .operand_b_i         (issue_i.op_b),
    .result_o            (alu_result),
    .comparison_result_o (alu_cmp_result)
  );

  ex_mult u_mult (
    .clk        (clk),
    .rst_n      (rst_n),
    .enable_i   (issue_i.mult_en),
    .operator_i (issue_i.mult_op),
    .op_a_i     (issue_i.op_a),
    .op_b_i     (issue_i.op_b),
    .ex_ready_i (ex_ready_o),
    .result_o   (mult_result),
    .ready_o    (mult_ready)
  );

  // Branch outcome goes straight back to fetch
  assign branch_decision_o = alu_cmp_result;
  assign jump_target_o     = issue_i.op_c;

  //////////////////////////////////////////////////////////////////////
  // Handshake
  //////////////////////////////////////////////////////////////////////

  assign units_ready = mult_ready & lsu_ready_ex_i & wb_ready_i;
  assign has_work    = issue_i.alu_en | issue_i.mult_en | issue_i.csr_access | issue_i.lsu_en;

  // Branches retire here and never wait on writeback
  assign ex_ready_o  = units_ready | issue_i.branch;
  assign ex_valid_o  = has_work & units_ready;

  // Forwarding port, CSR over multiplier over ALU
  always_comb begin
    fw_wr_o.we    = issue_i.fw_we & ex_valid_o;
    fw_wr_o.waddr = issue_i.fw_waddr;
    if (issue_i.csr_access) begin
      fw_wr_o.wdata = issue_i.csr_rdata;
    end else if (issue_i.mult_en) begin
      fw_wr_o.wdata = mult_result;
    end else if (issue_i.alu_en) begin
      fw_wr_o.wdata = alu_result;
    end else begin
      fw_wr_o.wdata = '0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // EX/WB register
  //////////////////////////////////////////////////////////////////////

  // Faulting loads never reach the register file
  assign load_wr = issue_i.lsu_en & issue_i.lsu_we & ~lsu_err_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lsu_we_q    <= 1'b0;
      lsu_waddr_q <= '0;
    end else if (ex_valid_o) begin
      lsu_we_q <= load_wr;
      if (load_wr) begin
        lsu_waddr_q <= issue_i.lsu_waddr;
      end
    end else if (wb_ready_i) begin
      // Nothing new this cycle, drain the pending load
      lsu_we_q <= 1'b0;
    end
  end

  // Load data arrives one cycle after issue
  assign wb_wr_o.we    = lsu_we_q;
  assign wb_wr_o.waddr = lsu_waddr_q;
  assign wb_wr_o.wdata = lsu_rdata_i;

endmodule

//--- src/ex_regfile.sv
//////////////////////////////////////////////////////////////////////
// Register file with a forwarding write port, a load write port and
// one asynchronous read port; x0 always reads zero
// RF_DEPTH of 16 gives an RV32E file and drops the top address bit
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module ex_regfile #(
  parameter int unsigned RF_DEPTH = 32
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  ex_pkg::rf_wr_t                fw_wr_i,
  input  ex_pkg::rf_wr_t                wb_wr_i,
  input  logic [ex_pkg::REG_ADDR_W-1:0] raddr_i,
  output logic [ex_pkg::XLEN-1:0]       rdata_o
);
  import ex_pkg::*;

  localparam int unsigned IDX_W = $clog2(RF_DEPTH);

  logic [XLEN-1:0]  mem_q [RF_DEPTH];
  logic [IDX_W-1:0] fw_idx;
  logic [IDX_W-1:0] wb_idx;
  logic [IDX_W-1:0] rd_idx;

  // Upper address bits above the file size are ignored
  assign fw_idx = fw_wr_i.waddr[IDX_W-1:0];
  assign wb_idx = wb_wr_i.waddr[IDX_W-1:0];
  assign rd_idx = raddr_i[IDX_W-1:0];

  //////////////////////////////////////////////////////////////////////
  // Write ports
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int unsigned i = 0; i < RF_DEPTH; i++) begin
        mem_q[i] <= '0;
      end
    end else begin
      if (wb_wr_i.we && (wb_idx != '0)) begin
        mem_q[wb_idx] <= wb_wr_i.wdata;
      end
      // Younger instruction, overrides the load on an address clash
      if (fw_wr_i.we && (fw_idx != '0)) begin
        mem_q[fw_idx] <= fw_wr_i.wdata;
      end
    end
  end

  // Read port, x0 hard-wired
  assign rdata_o = (rd_idx == '0) ? '0 : mem_q[rd_idx];

endmodule

//--- src/ex_top.sv
//////////////////////////////////////////////////////////////////////
// Execute stage subsystem: ex_stage driving a two-port register file
// Write ports are mirrored on fw_wr_o and wb_wr_o for observation
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module ex_top #(
  parameter int unsigned RF_DEPTH = 32
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  ex_pkg::ex_issue_t             issue_i,
  output logic                          ex_ready_o,
  output logic                          ex_valid_o,
  input  logic                          wb_ready_i,
  input  logic                          lsu_ready_ex_i,
  input  logic [ex_pkg::XLEN-1:0]       lsu_rdata_i,
  input  logic                          lsu_err_i,
  output ex_pkg::rf_wr_t                fw_wr_o,
  output ex_pkg::rf_wr_t                wb_wr_o,
  output logic                          branch_decision_o,
  output logic [ex_pkg::XLEN-1:0]       jump_target_o,
  input  logic [ex_pkg::REG_ADDR_W-1:0] rf_raddr_i,
  output logic [ex_pkg::XLEN-1:0]       rf_rdata_o
);
  import ex_pkg::*;

  rf_wr_t fw_wr;
  rf_wr_t wb_wr;

  ex_stage u_ex_stage (
    .clk               (clk),
    .rst_n             (rst_n),
    .issue_i           (issue_i),
    .wb_ready_i        (wb_ready_i),
    .lsu_ready_ex_i    (lsu_ready_ex_i),
    .lsu_rdata_i       (lsu_rdata_i),
    .lsu_err_i         (lsu_err_i),
    .fw_wr_o           (fw_wr),
    .wb_wr_o           (wb_wr),
    .branch_decision_o (branch_decision_o),
    .jump_target_o     (jump_target_o),
    .ex_ready_o        (ex_ready_o),
    .ex_valid_o        (ex_valid_o)
  );

  ex_regfile #(
    .RF_DEPTH (RF_DEPTH)
  ) u_regfile (
    .clk     (clk),
    .rst_n   (rst_n),
    .fw_wr_i (fw_wr),
    .wb_wr_i (wb_wr),
    .raddr_i (rf_raddr_i),
    .rdata_o (rf_rdata_o)
  );

  // Observation copies of both write ports
  assign fw_wr_o = fw_wr;
  assign wb_wr_o = wb_wr;

endmodule

//--- include/tb_ex_checks.svh
//////////////////////////////////////////////////////////////////////
// Compare tasks, error counters and reference models for the
// execute-stage testbench; included inside the testbench module
// after the package import
//////////////////////////////////////////////////////////////////////

`ifndef TB_EX_CHECKS_SVH
`define TB_EX_CHECKS_SVH

int check_count = 0;
int error_count = 0;

//////////////////////////////////////////////////////////////////////
// Compare tasks
//////////////////////////////////////////////////////////////////////

task automatic check_rf_wr(input string name, input rf_wr_t got, input rf_wr_t exp);
  check_count++;
  if (got !== exp) begin
    error_count++;
    $display("MISMATCH %s: got we=%0h waddr=%0h wdata=%h", name, got.we, got.waddr,
             got.wdata);
    $display("MISMATCH %s: expected we=%0h waddr=%0h wdata=%h", name, exp.we, exp.waddr,
             exp.wdata);
  end
endtask

task automatic check_word(input string name, input logic [XLEN-1:0] got,
                          input logic [XLEN-1:0] exp);
  check_count++;
  if (got !== exp) begin
    error_count++;
    $display("MISMATCH %s: got %h, expected %h", name, got, exp);
  end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  check_count++;
  if (got !== exp) begin
    error_count++;
    $display("MISMATCH %s: got %h, expected %h", name, got, exp);
  end
endtask

// One summary line per finished test
task automatic report_test(input string name, input int errs_before);
  if (error_count == errs_before) begin
    $display("test %s: ok", name);
  end else begin
    $display("test %s: %0d errors", name, error_count - errs_before);
  end
endtask

//////////////////////////////////////////////////////////////////////
// Reference models
//////////////////////////////////////////////////////////////////////

// RV32 compare semantics, SLT/SLTU share the LT/LTU rule
function automatic logic cmp_model(input alu_op_e op, input logic [XLEN-1:0] a,
                                   input logic [XLEN-1:0] b);
  logic r;
  case (op)
    EQ:        r = (a == b);
    NE:        r = (a != b);
    SLT, LT:   r = ($signed(a) < $signed(b));
    GE:        r = ($signed(a) >= $signed(b));
    SLTU, LTU: r = (a < b);
    GEU:       r = (a >= b);
    default:   r = 1'b0;
  endcase
  return r;
endfunction

function automatic logic [XLEN-1:0] alu_model(input alu_op_e op, input logic [XLEN-1:0] a,
                                              input logic [XLEN-1:0] b);
  logic [XLEN-1:0] r;
  case (op)
    ADD:     r = a + b;
    SUB:     r = a - b;
    AND:     r = a & b;
    OR:      r = a | b;
    XOR:     r = a ^ b;
    SLL:     r = a << b[4:0];
    SRL:     r = a >> b[4:0];
    SRA:     r = $signed(a) >>> b[4:0];
    // Set and compare ops write the flag
    default: r = {{(XLEN-1){1'b0}}, cmp_model(op, a, b)};
  endcase
  return r;
endfunction

// Full 64-bit product of the extended operands
function automatic logic [XLEN-1:0] mult_model(input mult_op_e op, input logic [XLEN-1:0] a,
                                               input logic [XLEN-1:0] b);
  logic [2*XLEN-1:0] ext_a;
  logic [2*XLEN-1:0] ext_b;
  logic [2*XLEN-1:0] prod;
  ext_a = {{XLEN{a[XLEN-1] & ((op == MULH) || (op == MULHSU))}}, a};
  ext_b = {{XLEN{b[XLEN-1] & (op == MULH)}}, b};
  prod  = ext_a * ext_b;
  return (op == MUL) ? prod[XLEN-1:0] : prod[2*XLEN-1:XLEN];
endfunction

`endif

//--- tb/tb_ex_top.sv
//////////////////////////////////////////////////////////////////////
// Directed testbench for the execute-stage subsystem
// Models decode and writeback, checks both write ports, branch
// outputs, the issue handshake and register file read-back
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_ex_top;
  import ex_pkg::*;

  // Generous bound over the whole test sequence incl. multiplier waits
  localparam int TIMEOUT_CYCLES = 600;
  // Longest handshake wait allowed per instruction
  localparam int MAX_WAIT       = 8;

  logic                  clk;
  logic                  rst_n;
  ex_issue_t             issue;
  logic                  wb_ready;
  logic                  lsu_ready_ex;
  logic [XLEN-1:0]       lsu_rdata;
  logic                  lsu_err;
  logic [REG_ADDR_W-1:0] rf_raddr;
  logic                  ex_ready;
  logic                  ex_valid;
  rf_wr_t                fw_wr;
  rf_wr_t                wb_wr;
  logic                  branch_decision;
  logic [XLEN-1:0]       jump_target;
  logic [XLEN-1:0]       rf_rdata;
  integer                seed;
  int                    cycle_count    = 0;
  int                    fw_write_count = 0;

  `include "tb_ex_checks.svh"

  ex_top #(
    .RF_DEPTH (32)
  ) DUT (
    .clk               (clk),
    .rst_n             (rst_n),
    .issue_i           (issue),
    .ex_ready_o        (ex_ready),
    .ex_valid_o        (ex_valid),
    .wb_ready_i        (wb_ready),
    .lsu_ready_ex_i    (lsu_ready_ex),
    .lsu_rdata_i       (lsu_rdata),
    .lsu_err_i         (lsu_err),
    .fw_wr_o           (fw_wr),
    .wb_wr_o           (wb_wr),
    .branch_decision_o (branch_decision),
    .jump_target_o     (jump_target),
    .rf_raddr_i        (rf_raddr),
    .rf_rdata_o        (rf_rdata)
  );

  // 20 ns clock
  always #10 clk = ~clk;

  // Cycle count for the watchdog and a tally of forwarding writes
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (fw_wr.we) begin
      fw_write_count <= fw_write_count + 1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////////////////////////

  function automatic ex_issue_t blank_issue();
    ex_issue_t ins;
    ins = '0;
    return ins;
  endfunction

  function automatic ex_issue_t alu_issue(input alu_op_e op, input logic [XLEN-1:0] a,
                                          input logic [XLEN-1:0] b,
                                          input logic [REG_ADDR_W-1:0] rd);
    ex_issue_t ins;
    ins          = '0;
    ins.alu_en   = 1'b1;
    ins.alu_op   = op;
    ins.op_a     = a;
    ins.op_b     = b;
    ins.fw_we    = 1'b1;
    ins.fw_waddr = rd;
    return ins;
  endfunction

  function automatic rf_wr_t expect_wr(input logic [REG_ADDR_W-1:0] rd,
                                       input logic [XLEN-1:0] data);
    rf_wr_t w;
    w.we    = 1'b1;
    w.waddr = rd;
    w.wdata = data;
    return w;
  endfunction

  // Drive on the rising edge, sample on the falling edge
  task automatic present(input ex_issue_t ins);
    @(posedge clk);
    issue <= ins;
    @(negedge clk);
  endtask

  // Retire the held instruction and point the read port at rd
  task automatic release_and_read(input logic [REG_ADDR_W-1:0] rd);
    @(posedge clk);
    issue    <= blank_issue();
    rf_raddr <= rd;
    @(negedge clk);
  endtask

  task automatic wait_ready(output int low_cycles);
    low_cycles = 0;
    while (!ex_ready && (low_cycles < MAX_WAIT)) begin
      low_cycles++;
      @(posedge clk);
      @(negedge clk);
    end
    if (!ex_ready) begin
      error_count++;
      $display("ex_ready_o stayed low for %0d cycles, instruction never accepted", low_cycles);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic alu_ops_writeback();
    int                    errs;
    alu_op_e               op;
    logic [XLEN-1:0]       a;
    logic [XLEN-1:0]       b;
    logic [XLEN-1:0]       exp;
    logic [XLEN-1:0]       exp_rd;
    logic [REG_ADDR_W-1:0] rd;
    errs = error_count;
    for (int i = 0; i <= 16; i++) begin
      op  = (i == 16) ? ADD : alu_op_e'(i);
      a   = $random(seed);
      b   = $random(seed);
      // Extra pass aims at x0
      rd  = (i == 16) ? '0 : REG_ADDR_W'(i + 1);
      exp = alu_model(op, a, b);
      exp_rd = (rd == '0) ? {XLEN{1'b0}} : exp;
      present(alu_issue(op, a, b, rd));
      check_rf_wr("fw_wr_o", fw_wr, expect_wr(rd, exp));
      check_bit("ex_ready_o", ex_ready, 1'b1);
      release_and_read(rd);
      check_word("rf_rdata_o", rf_rdata, exp_rd);
    end
    report_test("alu_ops_writeback", errs);
  endtask

  task automatic mult_latency();
    int                    errs;
    int                    low;
    mult_op_e              op;
    logic [XLEN-1:0]       a;
    logic [XLEN-1:0]       b;
    logic [XLEN-1:0]       exp;
    logic [REG_ADDR_W-1:0] rd;
    ex_issue_t             ins;
    errs = error_count;
    for (int i = 0; i < 8; i++) begin
      op = mult_op_e'(i % 4);
      // Random pass, then a signed corner pair
      a  = (i < 4) ? $random(seed) : 32'h8000_0001;
      b  = (i < 4) ? $random(seed) : 32'hffff_fff3;
      rd = REG_ADDR_W'(8 + i);
      exp = mult_model(op, a, b);
      ins          = blank_issue();
      ins.mult_en  = 1'b1;
      ins.mult_op  = op;
      ins.op_a     = a;
      ins.op_b     = b;
      ins.fw_we    = 1'b1;
      ins.fw_waddr = rd;
      present(ins);
      wait_ready(low);
      check_word("ex_ready_o low cycles", XLEN'(low), (op == MUL) ? 32'd0 : 32'd3);
      check_rf_wr("fw_wr_o", fw_wr, expect_wr(rd, exp));
      release_and_read(rd);
      check_word("rf_rdata_o", rf_rdata, exp);
    end
    report_test("mult_latency", errs);
  endtask

  task automatic load_writeback();
    int                    errs;
    logic [XLEN-1:0]       data;
    logic [REG_ADDR_W-1:0] rd;
    ex_issue_t             ins;
    errs = error_count;
    rd   = 5'd20;
    data = $random(seed);
    ins           = blank_issue();
    ins.lsu_en    = 1'b1;
    ins.lsu_we    = 1'b1;
    ins.lsu_waddr = rd;
    present(ins);
    check_bit("ex_valid_o", ex_valid, 1'b1);
    check_bit("wb_wr_o.we", wb_wr.we, 1'b0);
    // Load data returns one cycle later
    @(posedge clk);
    issue     <= blank_issue();
    lsu_rdata <= data;
    @(negedge clk);
    check_rf_wr("wb_wr_o", wb_wr, expect_wr(rd, data));
    release_and_read(rd);
    check_bit("wb_wr_o.we", wb_wr.we, 1'b0);
    check_word("rf_rdata_o", rf_rdata, data);
    // Faulting load to the same register
    @(posedge clk);
    issue   <= ins;
    lsu_err <= 1'b1;
    @(negedge clk);
    @(posedge clk);
    issue     <= blank_issue();
    lsu_err   <= 1'b0;
    lsu_rdata <= ~data;
    @(negedge clk);
    check_bit("wb_wr_o.we", wb_wr.we, 1'b0);
    release_and_read(rd);
    check_word("rf_rdata_o", rf_rdata, data);
    report_test("load_writeback", errs);
  endtask

  task automatic branch_compare();
    int              errs;
    alu_op_e         op;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] target;
    ex_issue_t       ins;
    errs = error_count;
    // Writeback stalled for the whole test
    @(posedge clk);
    wb_ready <= 1'b0;
    for (int i = 0; i < 12; i++) begin
      op     = alu_op_e'(10 + (i % 6));
      a      = $random(seed);
      // Second round uses equal operands
      b      = (i < 6) ? $random(seed) : a;
      target = $random(seed);
      ins        = alu_issue(op, a, b, '0);
      ins.fw_we  = 1'b0;
      ins.branch = 1'b1;
      ins.op_c   = target;
      present(ins);
      check_bit("branch_decision_o", branch_decision, cmp_model(op, a, b));
      check_word("jump_target_o", jump_target, target);
      check_bit("ex_ready_o", ex_ready, 1'b1);
    end
    @(posedge clk);
    issue    <= blank_issue();
    wb_ready <= 1'b1;
    report_test("branch_compare", errs);
  endtask

  task automatic csr_priority();
    int                    errs;
    logic [XLEN-1:0]       csr_data;
    logic [REG_ADDR_W-1:0] rd;
    ex_issue_t             ins;
    errs     = error_count;
    rd       = 5'd25;
    csr_data = $random(seed);
    ins            = alu_issue(ADD, $random(seed), $random(seed), rd);
    ins.csr_access = 1'b1;
    ins.csr_rdata  = csr_data;
    present(ins);
    check_rf_wr("fw_wr_o", fw_wr, expect_wr(rd, csr_data));
    release_and_read(rd);
    check_word("rf_rdata_o", rf_rdata, csr_data);
    report_test("csr_priority", errs);
  endtask

  task automatic wb_backpressure();
    int                    errs;
    int                    writes_before;
    logic [XLEN-1:0]       a;
    logic [XLEN-1:0]       b;
    logic [XLEN-1:0]       exp;
    logic [REG_ADDR_W-1:0] rd;
    errs = error_count;
    rd   = 5'd28;
    a    = $random(seed);
    b    = $random(seed);
    exp  = alu_model(SUB, a, b);
    writes_before = fw_write_count;
    @(posedge clk);
    issue    <= alu_issue(SUB, a, b, rd);
    wb_ready <= 1'b0;
    // Instruction held while writeback stalls, then for one LSU stall cycle
    for (int k = 0; k < 4; k++) begin
      @(negedge clk);
      check_bit("ex_ready_o", ex_ready, 1'b0);
      check_bit("ex_valid_o", ex_valid, 1'b0);
      check_bit("fw_wr_o.we", fw_wr.we, 1'b0);
      @(posedge clk);
      if (k == 2) begin
        wb_ready     <= 1'b1;
        lsu_ready_ex <= 1'b0;
      end
    end
    lsu_ready_ex <= 1'b1;
    @(negedge clk);
    check_bit("ex_ready_o", ex_ready, 1'b1);
    check_bit("ex_valid_o", ex_valid, 1'b1);
    check_rf_wr("fw_wr_o", fw_wr, expect_wr(rd, exp));
    release_and_read(rd);
    check_word("rf_rdata_o", rf_rdata, exp);
    check_word("forwarding write count", XLEN'(fw_write_count - writes_before), 32'd1);
    report_test("wb_backpressure", errs);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin : main
    clk          = 1'b0;
    rst_n        = 1'b0;
    issue        = blank_issue();
    wb_ready     = 1'b1;
    lsu_ready_ex = 1'b1;
    lsu_rdata    = '0;
    lsu_err      = 1'b0;
    rf_raddr     = '0;
    seed         = 32'h3fb7_fa12;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    alu_ops_writeback();
    mult_latency();
    load_writeback();
    branch_compare();
    csr_priority();
    wb_backpressure();
    repeat (2) @(posedge clk);
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    wait (cycle_count >= TIMEOUT_CYCLES);
    $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+include
src/ex_pkg.sv
src/ex_alu.sv
src/ex_mult.sv
src/ex_stage.sv
src/ex_regfile.sv
src/ex_top.sv
tb/tb_ex_top.sv

//--- run_sim.sh
#!/bin/sh
# Build the execute-stage testbench with Verilator and run it.
# Exit status is 0 only when the testbench reports a pass.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f verilog.f \
  --top-module tb_ex_top --Mdir obj_dir -o sim_ex_top
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit 1
fi

sim_out=$(./obj_dir/sim_ex_top)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qxF "RESULT: PASS"; then
  exit 0
fi
echo "Pass line not found in simulation output"
exit 1
